// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - design/soc_map_pkg.sv
  - design/lsu_pkg.sv
  - design/memop_decode.sv
  - design/lsu_request.sv
  - design/load_extend.sv
  - design/clint_timer.sv
  - design/data_ram.sv
  - design/mem_stage.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_mem_stage.sv

// ==== design/clint_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         sel_i,
  input  wire logic                         we_i,
  input  wire logic [soc_map_pkg::XLEN-1:0] addr_i,
  input  wire logic [soc_map_pkg::XLEN-1:0] wdata_i,
  output logic [soc_map_pkg::XLEN-1:0]      rdata_o,
  output logic                              timer_irq_o
);

  import soc_map_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        wr_en;

  assign wr_en = sel_i & we_i;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mtime       <= '0;
      mtimecmp    <= '1;  // no interrupt until software programs it
      timer_irq_o <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;  // free running
      if (wr_en && addr_i == MTIMECMP_LO_ADDR) begin
        mtimecmp[31:0] <= wdata_i;
      end
      if (wr_en && addr_i == MTIMECMP_HI_ADDR) begin
        mtimecmp[63:32] <= wdata_i;
      end
      timer_irq_o <= (mtime >= mtimecmp);
    end
  end

  // read mux, answers in the same cycle
  always_comb begin
    rdata_o = '0;
    if (sel_i) begin
      case (addr_i)
        MTIME_LO_ADDR:    rdata_o = mtime[31:0];
        MTIME_HI_ADDR:    rdata_o = mtime[63:32];
        MTIMECMP_LO_ADDR: rdata_o = mtimecmp[31:0];
        MTIMECMP_HI_ADDR: rdata_o = mtimecmp[63:32];
        default:          rdata_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire lsu_pkg::mem_req_t       req_i,
  output logic                         ready_o,
  output logic [soc_map_pkg::XLEN-1:0] rdata_o
);

  import soc_map_pkg::*;
  import lsu_pkg::*;

  logic [XLEN-1:0]       mem [RAM_WORDS];
  mem_req_t              req_q;  // request held during the access
  logic                  busy;
  logic [RAM_CNT_W-1:0]  cnt;
  logic                  start;
  logic                  done;
  logic [RAM_ADDR_W-1:0] idx;

  assign start = req_i.valid & ~busy;
  assign done  = busy & (cnt == RAM_CNT_W'(1));
  assign idx   = req_q.addr[RAM_ADDR_W+1:2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy    <= 1'b0;
      cnt     <= '0;
      ready_o <= 1'b0;
    end else begin
      ready_o <= done;  // one-cycle pulse
      if (start) begin
        busy <= 1'b1;
        cnt  <= RAM_CNT_W'(RAM_LATENCY - 1);
      end else if (busy) begin
        busy <= ~done;
        cnt  <= cnt - 1'b1;
      end
    end
  end

  // storage and read data
  always_ff @(posedge clk) begin
    if (start) begin
      req_q <= req_i;
    end
    if (done) begin
      rdata_o <= mem[idx];
      if (req_q.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req_q.mask[b]) mem[idx][8*b +: 8] <= req_q.wdata[8*b +: 8];  // masked lane
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/load_extend.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_extend (
  input  wire lsu_pkg::mem_in_t             in_i,
  input  wire lsu_pkg::ls_ctrl_t            ctrl_i,
  input  wire logic                         clint_sel_i,
  input  wire logic                         ram_ready_i,
  input  wire logic [soc_map_pkg::XLEN-1:0] ram_rdata_i,
  input  wire logic [soc_map_pkg::XLEN-1:0] clint_rdata_i,
  output lsu_pkg::wb_t                      wb_o
);

  import soc_map_pkg::*;

  logic [XLEN-1:0] raw;
  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] ext;

  always_comb begin
    // ram data only counts in the ready cycle
    if (clint_sel_i) begin
      raw = clint_rdata_i;
    end else begin
      raw = ram_ready_i ? ram_rdata_i : '0;
    end

    shifted = raw >> {in_i.alu_data[1:0], 3'b000};  // addressed byte to bit 0

    if (ctrl_i.size[0]) begin
      ext = {{(XLEN-8){ctrl_i.is_signed & shifted[7]}}, shifted[7:0]};
    end else if (ctrl_i.size[1]) begin
      ext = {{(XLEN-16){ctrl_i.is_signed & shifted[15]}}, shifted[15:0]};
    end else begin
      ext = shifted;
    end
  end

  always_comb begin
    wb_o.inst_addr = in_i.inst_addr;
    wb_o.rd_idx    = in_i.rd_idx;
    if (ctrl_i.is_none) begin
      wb_o.data = in_i.alu_data;  // alu result passes straight on
    end else if (ctrl_i.is_load) begin
      wb_o.data = ext;
    end else begin
      wb_o.data = '0;  // stores write nothing back
    end
  end

endmodule

`default_nettype wire

// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // memory operation code from execute
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LBU  = 4'd2,
    LH   = 4'd3,
    LHU  = 4'd4,
    LW   = 4'd5,
    SB   = 4'd6,
    SH   = 4'd7,
    SW   = 4'd8
  } memop_e;

  // decoded controls
  typedef struct packed {
    logic       is_load;
    logic       is_store;
    logic       is_none;
    logic [2:0] size;       // one-hot: [0] byte, [1] half, [2] word
    logic       is_signed;  // sign-extend loads
  } ls_ctrl_t;

  // stage input from execute
  typedef struct packed {
    logic [soc_map_pkg::XLEN-1:0]      inst_addr;
    logic [soc_map_pkg::REG_IDX_W-1:0] rd_idx;
    memop_e                            mem_op;
    logic [soc_map_pkg::XLEN-1:0]      alu_data;  // address or alu result
    logic [soc_map_pkg::XLEN-1:0]      rs2_data;
  } mem_in_t;

  // request to data ram
  typedef struct packed {
    logic [soc_map_pkg::XLEN-1:0] addr;
    logic [soc_map_pkg::XLEN-1:0] wdata;  // already lane-shifted
    logic [3:0]                   mask;
    logic                         write;  // first valid cycle of a store only
    logic                         valid;
  } mem_req_t;

  // writeback record
  typedef struct packed {
    logic [soc_map_pkg::XLEN-1:0]      inst_addr;
    logic [soc_map_pkg::REG_IDX_W-1:0] rd_idx;
    logic [soc_map_pkg::XLEN-1:0]      data;
  } wb_t;

endpackage

`default_nettype wire

// ==== design/lsu_request.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_request (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire lsu_pkg::ls_ctrl_t            ctrl_i,
  input  wire logic [soc_map_pkg::XLEN-1:0] addr_i,
  input  wire logic [soc_map_pkg::XLEN-1:0] rs2_i,
  input  wire logic                         ram_ready_i,
  output lsu_pkg::mem_req_t                 req_o,
  output logic                              clint_sel_o,
  output logic                              clint_we_o,
  output logic [soc_map_pkg::XLEN-1:0]      clint_addr_o,
  output logic [soc_map_pkg::XLEN-1:0]      clint_wdata_o,
  output logic                              stall_o
);

  import soc_map_pkg::*;

  logic       mem_op;
  logic       in_clint;
  logic       ram_op;
  logic [3:0] size_mask;
  logic       write_sent;  // store already issued to the ram

  assign mem_op = ctrl_i.is_load | ctrl_i.is_store;

  // clint window
  assign in_clint = (addr_i == MTIME_LO_ADDR)    |
                    (addr_i == MTIME_HI_ADDR)    |
                    (addr_i == MTIMECMP_LO_ADDR) |
                    (addr_i == MTIMECMP_HI_ADDR);

  assign ram_op = mem_op & ~in_clint;

  assign size_mask = ({4{ctrl_i.size[0]}} & 4'b0001) |
                     ({4{ctrl_i.size[1]}} & 4'b0011) |
                     ({4{ctrl_i.size[2]}} & 4'b1111);

  always_comb begin
    req_o.addr  = addr_i;
    req_o.mask  = size_mask << addr_i[1:0];
    req_o.wdata = rs2_i << {addr_i[1:0], 3'b000};  // move data onto its byte lanes
    req_o.valid = ram_op & ~ram_ready_i;
    req_o.write = ctrl_i.is_store & req_o.valid & ~write_sent;
  end

  // clint side, done in one cycle
  assign clint_sel_o   = mem_op & in_clint;
  assign clint_we_o    = ctrl_i.is_store & in_clint;
  assign clint_addr_o  = addr_i;
  assign clint_wdata_o = rs2_i;

  assign stall_o = req_o.valid;

  // valid stays up for the whole access, the write bit only once
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      write_sent <= 1'b0;
    end else if (ram_ready_i) begin
      write_sent <= 1'b0;  // access finished
    end else if (req_o.write) begin
      write_sent <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire lsu_pkg::mem_in_t mem_in_i,
  output lsu_pkg::wb_t          wb_o,
  output logic                  stall_o,
  output logic                  timer_irq_o
);

  import soc_map_pkg::*;
  import lsu_pkg::*;

  ls_ctrl_t        ctrl;
  mem_req_t        ram_req;
  logic            ram_ready;
  logic [XLEN-1:0] ram_rdata;
  logic            clint_sel;
  logic            clint_we;
  logic [XLEN-1:0] clint_addr;
  logic [XLEN-1:0] clint_wdata;
  logic [XLEN-1:0] clint_rdata;

  memop_decode u_decode (
    .mem_op_i (mem_in_i.mem_op),
    .ctrl_o   (ctrl)
  );

  lsu_request u_request (
    .clk           (clk),
    .rst           (rst),
    .ctrl_i        (ctrl),
    .addr_i        (mem_in_i.alu_data),  // alu computed the address
    .rs2_i         (mem_in_i.rs2_data),
    .ram_ready_i   (ram_ready),
    .req_o         (ram_req),
    .clint_sel_o   (clint_sel),
    .clint_we_o    (clint_we),
    .clint_addr_o  (clint_addr),
    .clint_wdata_o (clint_wdata),
    .stall_o       (stall_o)
  );

  load_extend u_result (
    .in_i          (mem_in_i),
    .ctrl_i        (ctrl),
    .clint_sel_i   (clint_sel),
    .ram_ready_i   (ram_ready),
    .ram_rdata_i   (ram_rdata),
    .clint_rdata_i (clint_rdata),
    .wb_o          (wb_o)
  );

  clint_timer u_clint (
    .clk         (clk),
    .rst         (rst),
    .sel_i       (clint_sel),
    .we_i        (clint_we),
    .addr_i      (clint_addr),
    .wdata_i     (clint_wdata),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o)
  );

  data_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .req_i   (ram_req),
    .ready_o (ram_ready),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== design/memop_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module memop_decode (
  input  wire lsu_pkg::memop_e mem_op_i,
  output lsu_pkg::ls_ctrl_t    ctrl_o
);

  import lsu_pkg::*;

  logic op_lb;
  logic op_lbu;
  logic op_lh;
  logic op_lhu;
  logic op_lw;
  logic op_sb;
  logic op_sh;
  logic op_sw;

  // one compare per operation
  assign op_lb  = (mem_op_i == LB);
  assign op_lbu = (mem_op_i == LBU);
  assign op_lh  = (mem_op_i == LH);
  assign op_lhu = (mem_op_i == LHU);
  assign op_lw  = (mem_op_i == LW);
  assign op_sb  = (mem_op_i == SB);
  assign op_sh  = (mem_op_i == SH);
  assign op_sw  = (mem_op_i == SW);

  always_comb begin
    ctrl_o.is_load   = op_lb | op_lbu | op_lh | op_lhu | op_lw;
    ctrl_o.is_store  = op_sb | op_sh | op_sw;
    // anything unrecognised falls back to none
    ctrl_o.is_none   = ~(ctrl_o.is_load | ctrl_o.is_store);
    ctrl_o.size[0]   = op_lb | op_lbu | op_sb;
    ctrl_o.size[1]   = op_lh | op_lhu | op_sh;
    ctrl_o.size[2]   = op_lw | op_sw;
    ctrl_o.is_signed = op_lb | op_lh;  // word loads need no extension
  end

endmodule

`default_nettype wire

// ==== design/soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

  // core widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // clint register map, word addresses
  localparam logic [XLEN-1:0] MTIMECMP_LO_ADDR = 32'h0200_4000;
  localparam logic [XLEN-1:0] MTIMECMP_HI_ADDR = 32'h0200_4004;
  localparam logic [XLEN-1:0] MTIME_LO_ADDR    = 32'h0200_bff8;
  localparam logic [XLEN-1:0] MTIME_HI_ADDR    = 32'h0200_bffc;

  // data ram geometry
  localparam int RAM_WORDS  = 256;
  localparam int RAM_ADDR_W = $clog2(RAM_WORDS);  // word index bits

  // request start to ready pulse, in cycles (2 or more)
  localparam int RAM_LATENCY = 2;
  localparam int RAM_CNT_W   = $clog2(RAM_LATENCY + 1);

endpackage

`default_nettype wire

// ==== sim.f ====
design/soc_map_pkg.sv
design/lsu_pkg.sv
design/memop_decode.sv
design/lsu_request.sv
design/load_extend.sv
design/clint_timer.sv
design/data_ram.sv
design/mem_stage.sv
tb/tb_clk_gen.sv
tb/tb_mem_stage.sv

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release reset away from the rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;

  import soc_map_pkg::*;
  import lsu_pkg::*;

  localparam int MAX_ROWS    = 64;
  localparam int STALL_LIMIT = 16;  // cycles
  localparam int IRQ_LIMIT   = 8;

  typedef struct packed {
    mem_in_t stim;
    wb_t     exp;
    logic    stall;    // ram access so stall comes first
    logic    irq_chk;  // wait for a timer level after the row
    logic    irq_val;
  } row_t;

  logic        clk;
  logic        rst;
  mem_in_t     mem_in;
  wb_t         wb;
  logic        stall;
  logic        timer_irq;
  row_t        rows [MAX_ROWS];
  string       names [MAX_ROWS];
  int          n_rows;
  logic [7:0]  ram_model [1024];  // byte image of the low ram
  logic [31:0] cmp_lo;
  logic [31:0] cmp_hi;
  integer      seed;
  int          errors;
  int          timeouts;

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(5)) u_clk (.clk_o(clk), .rst_o(rst));

  mem_stage u_dut (
    .clk         (clk),
    .rst         (rst),
    .mem_in_i    (mem_in),
    .wb_o        (wb),
    .stall_o     (stall),
    .timer_irq_o (timer_irq)
  );

  function automatic int op_bytes(input memop_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      default:     return 4;
    endcase
  endfunction

  // gather bytes from the model and read lanes past the word as zero
  function automatic logic [31:0] load_model(input memop_e op, input logic [31:0] addr);
    logic [31:0] v;
    int          off;
    v   = '0;
    off = addr[1:0];
    for (int i = 0; i < op_bytes(op); i++) begin
      if (off + i < 4) v[8*i +: 8] = ram_model[{addr[9:2], 2'b00} + off + i];
    end
    case (op)
      LB:      v = {{24{v[7]}}, v[7:0]};
      LH:      v = {{16{v[15]}}, v[15:0]};
      default: ;
    endcase
    return v;
  endfunction

  task automatic add_row(input string name, input memop_e op, input logic [31:0] addr,
                         input logic [31:0] rs2);
    row_t r;
    logic clint;
    int   off;
    clint = (addr == MTIME_LO_ADDR) || (addr == MTIME_HI_ADDR) ||
            (addr == MTIMECMP_LO_ADDR) || (addr == MTIMECMP_HI_ADDR);
    off = addr[1:0];
    r = '0;  // stores expect zero data
    r.stim.inst_addr = 32'h0000_1000 + 32'(4 * n_rows);
    r.stim.rd_idx    = REG_IDX_W'(n_rows);
    r.stim.mem_op    = op;
    r.stim.alu_data  = addr;
    r.stim.rs2_data  = rs2;
    r.exp.inst_addr  = r.stim.inst_addr;
    r.exp.rd_idx     = r.stim.rd_idx;
    r.stall          = (op != NONE) && !clint;
    if (op == NONE) begin
      r.exp.data = addr;
    end else if (op == SB || op == SH || op == SW) begin
      if (addr == MTIMECMP_LO_ADDR) cmp_lo = rs2;
      if (addr == MTIMECMP_HI_ADDR) cmp_hi = rs2;
      for (int i = 0; i < op_bytes(op); i++) begin
        if (!clint && off + i < 4) ram_model[{addr[9:2], 2'b00} + off + i] = rs2[8*i +: 8];
      end
    end else if (clint) begin
      r.exp.data = (addr == MTIMECMP_LO_ADDR) ? cmp_lo : cmp_hi;
    end else begin
      r.exp.data = load_model(op, addr);
    end
    rows[n_rows]  = r;
    names[n_rows] = name;
    n_rows++;
  endtask

  task automatic expect_irq(input logic val);
    rows[n_rows-1].irq_chk = 1'b1;
    rows[n_rows-1].irq_val = val;
  endtask

  task automatic build_table();
    logic [31:0] data;
    add_row("none pass", NONE, $random(seed), $random(seed));
    add_row("sw word", SW, 32'h40, $random(seed));
    add_row("lw word", LW, 32'h40, 32'h0);
    add_row("sw fill", SW, 32'h80, $random(seed));
    for (int o = 0; o < 4; o++) begin
      add_row($sformatf("sb off %0d", o), SB, 32'h80 + o, $random(seed));
      add_row($sformatf("lw after sb %0d", o), LW, 32'h80, 32'h0);
      add_row($sformatf("sh off %0d", o), SH, 32'h80 + o, $random(seed));
      add_row($sformatf("lw after sh %0d", o), LW, 32'h80, 32'h0);
    end
    for (int o = 0; o < 4; o++) begin
      data = $random(seed);
      // every byte negative on even offsets and positive on odd ones
      data = o[0] ? (data & 32'h7f7f_7f7f) : (data | 32'h8080_8080);
      add_row($sformatf("sw data %0d", o), SW, 32'hc0, data);
      add_row($sformatf("lb off %0d", o), LB, 32'hc0 + o, 32'h0);
      add_row($sformatf("lbu off %0d", o), LBU, 32'hc0 + o, 32'h0);
      add_row($sformatf("lh off %0d", o), LH, 32'hc0 + o, 32'h0);
      add_row($sformatf("lhu off %0d", o), LHU, 32'hc0 + o, 32'h0);
    end
    add_row("cmp lo write", SW, MTIMECMP_LO_ADDR, $random(seed));
    add_row("cmp hi write", SW, MTIMECMP_HI_ADDR, 32'h8000_0000 | $random(seed));  // stays far ahead
    add_row("cmp lo read", LW, MTIMECMP_LO_ADDR, 32'h0);
    add_row("cmp hi read", LW, MTIMECMP_HI_ADDR, 32'h0);
    add_row("cmp lo zero", SW, MTIMECMP_LO_ADDR, 32'h0);
    add_row("cmp hi zero", SW, MTIMECMP_HI_ADDR, 32'h0);
    expect_irq(1'b1);
    add_row("cmp hi ones", SW, MTIMECMP_HI_ADDR, '1);
    expect_irq(1'b0);
    add_row("cmp lo ones", SW, MTIMECMP_LO_ADDR, '1);
  endtask

  task automatic check_wb(input string name, input wb_t exp, input wb_t act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_row(input int i);
    int cnt;
    mem_in = rows[i].stim;
    @(negedge clk);
    check_bit({names[i], " stall"}, rows[i].stall, stall);
    cnt = 0;
    while (stall !== 1'b0 && cnt < STALL_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (stall !== 1'b0) begin
      $display("%s: stall never released", names[i]);
      timeouts++;
    end else begin
      check_wb(names[i], rows[i].exp, wb);
    end
    cnt = 0;
    while (rows[i].irq_chk && timer_irq !== rows[i].irq_val && cnt < IRQ_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (rows[i].irq_chk && timer_irq !== rows[i].irq_val) begin
      $display("%s: timer interrupt did not reach the expected level", names[i]);
      timeouts++;
    end
  endtask

  initial begin
    int cnt;
    seed     = 32'hc7cc_d07d;
    mem_in   = '0;
    errors   = 0;
    timeouts = 0;
    n_rows   = 0;
    cmp_lo   = '1;  // reset value of mtimecmp
    cmp_hi   = '1;
    build_table();
    cnt = 0;
    while (rst !== 1'b0 && cnt < 20) begin
      @(posedge clk);
      cnt++;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released");
      timeouts++;
    end
    @(negedge clk);
    check_bit("stall after reset", 1'b0, stall);
    check_bit("irq after reset", 1'b0, timer_irq);
    for (int i = 0; i < n_rows && timeouts == 0; i++) begin
      run_row(i);
    end
    $display("%0d check errors, %0d wait failures", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
